// File: all.f
logic/fetch_pkg.sv
logic/pc_next.sv
logic/fetch_ctrl.sv
logic/inst_align.sv
logic/fetch_top.sv
bench/tb_clock.sv
bench/mem_model.sv
bench/fetch_tb.sv

// File: bench/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

    localparam addr_t RESET_PC = 64'h8000_1000;
    localparam addr_t MTVEC    = 64'h8000_0100;
    localparam int    WAIT_MAX = 200;

    typedef enum int {K_NONE, K_JAL, K_BR_TAKEN, K_BR_NOT, K_JALR, K_TRAP, K_JAL_TRAP} kind_e;

    logic       clk;
    logic       rst;
    logic       ar_valid;
    logic       ar_ready;
    addr_t      ar_addr;
    logic [7:0] ar_size;
    logic       r_valid;
    logic       r_ready;
    mem_word_u  r_data;
    logic       br_jal;
    logic       br_branch;
    logic       br_jalr;
    logic       trap;
    addr_t      br_alu_res;
    addr_t      br_pc;
    addr_t      br_imm;
    addr_t      br_rs1;
    addr_t      mtvec;
    logic       stall;
    logic       inst_valid;
    inst_t      inst;
    addr_t      pc;
    logic       size_err;

    kind_e kind_q[$];
    addr_t base_q[$];    // br_pc_i or br_rs1_i for jalr
    addr_t imm_q[$];
    int    stall_q[$];
    int    delay_q[$];   // cycles from the last instruction to the strobe
    int    count_q[$];
    addr_t expect_q[$];  // expected pcs of all rows back to back
    int    row;
    int    pos;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(4)) tb_clock_i (.clk(clk), .rst_o(rst));

    mem_model #(.SEED(32'hdc0c72fb)) mem_model_i (
        .clk(clk), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .ar_addr_i(ar_addr), .ar_size_i(ar_size), .r_valid_o(r_valid),
        .r_ready_i(r_ready), .r_data_o(r_data), .size_err_o(size_err)
    );

    fetch_top #(.RESET_PC(RESET_PC)) fetch_top_i (
        .clk(clk), .rst_i(rst),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
        .ar_size_o(ar_size), .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data),
        .br_jal_i(br_jal), .br_branch_i(br_branch), .br_jalr_i(br_jalr), .trap_i(trap),
        .br_alu_res_i(br_alu_res), .br_pc_i(br_pc), .br_imm_i(br_imm), .br_rs1_i(br_rs1),
        .mtvec_i(mtvec), .stall_i(stall),
        .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(pc)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // memory fill rule seen from the pc side
    function automatic inst_t expected_inst(addr_t a);
        return a[31:0] ^ a[63:32] ^ 32'h1300_0000;
    endfunction

    task automatic add_row(input kind_e kind, input addr_t base, input addr_t imm,
                           input int stall_n, input int delay_n, input int n,
                           input addr_t e0, input addr_t e1, input addr_t e2);
        kind_q.push_back(kind);
        base_q.push_back(base);
        imm_q.push_back(imm);
        stall_q.push_back(stall_n);
        delay_q.push_back(delay_n);
        count_q.push_back(n);
        expect_q.push_back(e0);
        if (n > 1) expect_q.push_back(e1);
        if (n > 2) expect_q.push_back(e2);
    endtask

    task automatic load_table();
        // kind, base, imm, stall, delay, count, then the expected pcs
        add_row(K_NONE, '0, '0, 0, 0, 3,
                64'h8000_1000, 64'h8000_1004, 64'h8000_1008);
        add_row(K_JAL, 64'h8000_1008, 64'h100, 0, 1, 2,
                64'h8000_1108, 64'h8000_110c, '0);
        add_row(K_BR_TAKEN, 64'h8000_110c, 64'hffff_ffff_ffff_ffc0, 0, 2, 2,
                64'h8000_10cc, 64'h8000_10d0, '0);
        add_row(K_BR_NOT, 64'h8000_10d0, 64'h40, 0, 0, 2,
                64'h8000_10d4, 64'h8000_10d8, '0);
        add_row(K_JALR, 64'h8000_2001, 64'h10, 0, 1, 2,  // odd sum
                64'h8000_2010, 64'h8000_2014, '0);
        add_row(K_JAL_TRAP, 64'h8000_3000, 64'h8, 0, 2, 1,
                64'h8000_3008, '0, '0);
        add_row(K_TRAP, '0, '0, 0, 2, 3,
                64'h8000_0100, 64'h8000_0104, 64'h8000_0108);
        add_row(K_NONE, '0, '0, 5, 0, 2,
                64'h8000_010c, 64'h8000_0110, '0);
        add_row(K_JAL, 64'h8000_4000, 64'h4, 3, 0, 2,
                64'h8000_4004, 64'h8000_4008, '0);
        add_row(K_BR_TAKEN, 64'h8000_4008, 64'h20, 2, 2, 1,
                64'h8000_4028, '0, '0);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            fail_run("reset was never released");
        end
        @(negedge clk);
    endtask

    task automatic wait_inst();
        int           cycles;
        fetch_state_e st;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (inst_valid !== 1'b1 && cycles < WAIT_MAX);
        if (inst_valid !== 1'b1) begin
            st = fetch_top_i.fetch_ctrl_i.state;
            fail_run($sformatf("timeout after %0d cycles without an instruction, fetch state %s",
                               WAIT_MAX, st.name()));
        end
    endtask

    // one cycle in which no instruction may come out
    task automatic quiet_cycle(input logic stalled);
        @(negedge clk);
        check_flag("inst_valid_o", inst_valid, 1'b0);
        check_inst("inst_o", inst, '0);
        check_addr("pc_o", pc, '0);
        if (stalled) begin
            check_flag("ar_valid_o", ar_valid, 1'b0);
            check_flag("r_ready_o", r_ready, 1'b0);
        end
    endtask

    task automatic drive_redirect(input kind_e kind, input addr_t base, input addr_t imm);
        br_pc      = base;
        br_rs1     = base;
        br_imm     = imm;
        br_alu_res = (kind == K_BR_NOT) ? 64'd1 : 64'd0;  // zero means taken
        br_jal     = (kind == K_JAL) || (kind == K_JAL_TRAP);
        br_branch  = (kind == K_BR_TAKEN) || (kind == K_BR_NOT);
        br_jalr    = (kind == K_JALR);
        trap       = (kind == K_TRAP) || (kind == K_JAL_TRAP);
    endtask

    task automatic clear_redirect();
        br_jal    = 1'b0;
        br_branch = 1'b0;
        br_jalr   = 1'b0;
        trap      = 1'b0;
    endtask

    initial begin
        clear_redirect();
        stall      = 1'b0;
        br_alu_res = '0;
        br_pc      = '0;
        br_imm     = '0;
        br_rs1     = '0;
        mtvec      = MTVEC;
        pos        = 0;
        load_table();
        wait_reset_release();
        for (row = 0; row < kind_q.size(); row++) begin
            if (stall_q[row] > 0) begin
                stall = 1'b1;
                repeat (stall_q[row]) quiet_cycle(1'b1);
                stall = 1'b0;
            end
            repeat (delay_q[row]) quiet_cycle(1'b0);  // read may be in flight here
            if (kind_q[row] != K_NONE) begin
                drive_redirect(kind_q[row], base_q[row], imm_q[row]);
                quiet_cycle(1'b0);
                clear_redirect();
            end
            repeat (count_q[row]) begin
                wait_inst();
                check_addr("pc_o", pc, expect_q[pos]);
                check_inst("inst_o", inst, expected_inst(expect_q[pos]));
                if (size_err) begin
                    fail_run("memory saw a read size code other than FETCH_SIZE");
                end
                pos++;
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: bench/mem_model.sv
module mem_model import fetch_pkg::*; #(
    parameter int unsigned SEED = 32'd1
) (
    input  logic       clk,
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    input  addr_t      ar_addr_i,
    input  logic [7:0] ar_size_i,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output mem_word_u  r_data_o,
    output logic       size_err_o  // sticky flag for a read with another size code
);

    int unsigned ar_wait;   // cycles before ar_ready
    int unsigned r_wait;    // cycles before the read beat
    int          phase;     // 0 address, 1 data, 2 beat on the bus
    addr_t       rd_addr;

    // one slot of the fill with the upper address bits folded in
    function automatic inst_t slot_at(addr_t a);
        return a[31:0] ^ a[63:32] ^ 32'h1300_0000;
    endfunction

    function automatic mem_word_u word_at(addr_t a);
        mem_word_u w;
        addr_t     base;
        base  = {a[63:3], 3'b000};
        w.raw = {slot_at(base + 64'd4), slot_at(base)};
        return w;
    endfunction

    // everything moves on the falling edge and the fetch unit samples on the rising one
    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        size_err_o = 1'b0;
        phase      = 0;
        r_wait     = 0;
        void'($urandom(SEED));  // one seed for the whole run
        ar_wait    = $urandom_range(3, 0);
        forever begin
            @(negedge clk);
            case (phase)
                0: begin
                    if (ar_valid_i === 1'b1) begin
                        if (ar_wait == 0) begin
                            ar_ready_o = 1'b1;  // address taken on the coming edge
                            rd_addr    = ar_addr_i;
                            if (ar_size_i !== FETCH_SIZE) begin
                                size_err_o = 1'b1;
                            end
                            r_wait = $urandom_range(3, 0);
                            phase  = 1;
                        end else begin
                            ar_wait--;
                        end
                    end
                end
                1: begin
                    ar_ready_o = 1'b0;
                    if (r_ready_i === 1'b1) begin
                        if (r_wait == 0) begin
                            r_valid_o = 1'b1;
                            r_data_o  = word_at(rd_addr);
                            phase     = 2;
                        end else begin
                            r_wait--;
                        end
                    end
                end
                default: begin
                    // beat went out on the last rising edge
                    r_valid_o = 1'b0;
                    r_data_o  = '0;
                    ar_wait   = $urandom_range(3, 0);
                    phase     = 0;
                end
            endcase
        end
    end

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // release between sampling edges
        rst_o = 1'b0;
    end

endmodule

// File: logic/fetch_ctrl.sv
module fetch_ctrl import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       stall_i,     // hold from decode
    input  logic       redirect_i,  // pc jumps on the next edge
    input  logic       ar_ready_i,
    input  logic       r_valid_i,
    input  addr_t      pc_i,
    output logic       ar_valid_o,
    output logic       r_ready_o,
    output logic       pc_advance_o,
    output logic       accept_o,
    output addr_t      ar_addr_o,
    output logic [7:0] ar_size_o
);

    fetch_state_e state;
    fetch_state_e state_next;
    addr_t        addr_q;   // address of the read in flight
    logic         addr_hs;  // address taken this cycle
    logic         data_hs;  // read beat taken this cycle
    logic         start;    // leave idle with a new read
    logic         match;    // response still belongs to the live pc

    assign ar_valid_o = (state == ADDR);
    assign r_ready_o  = (state == DATA);  // only once the address is gone
    assign ar_addr_o  = addr_q;
    assign ar_size_o  = FETCH_SIZE;

    assign addr_hs = ar_valid_o & ar_ready_i;
    assign data_hs = r_ready_o & r_valid_i;

    // back-pressure from decode stops new reads only
    // a pc about to be replaced is not worth a read either
    assign start = ~stall_i & ~redirect_i;

    // stale if the pc moved since issue or moves now
    assign match = (addr_q == pc_i) & ~redirect_i;

    assign accept_o     = data_hs & match;
    assign pc_advance_o = accept_o;  // pc steps only on a used response

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = ADDR;
                end
            end
            ADDR: begin
                if (addr_hs) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                // stale beats are dropped here too and idle reissues at the new pc
                if (data_hs) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // loads when leaving idle and holds through address and data phase
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            addr_q <= pc_i;
        end
    end

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

    typedef logic [63:0] addr_t;  // byte address
    typedef logic [31:0] inst_t;  // one uncompressed instruction

    // read beat from the memory port
    // the memory side fills it whole and the aligner reads it by slot
    typedef union packed {
        logic [63:0] raw;
        inst_t [1:0] half;  // half[0] is the low word
    } mem_word_u;

    typedef enum logic [1:0] {
        IDLE = 2'd0,  // ready to issue the next read
        ADDR = 2'd1,  // address phase, valid held high
        DATA = 2'd2   // waiting for the read beat
    } fetch_state_e;

    // size code driven with every fetch read
    localparam logic [7:0] FETCH_SIZE = 8'h0f;

endpackage

// File: logic/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
    parameter addr_t RESET_PC = 64'h8000_0000
) (
    input  logic       clk,
    input  logic       rst_i,

    // memory read port
    output logic       ar_valid_o,
    input  logic       ar_ready_i,
    output addr_t      ar_addr_o,
    output logic [7:0] ar_size_o,
    input  logic       r_valid_i,
    output logic       r_ready_o,
    input  mem_word_u  r_data_i,

    // redirects from the memory stage
    input  logic       br_jal_i,
    input  logic       br_branch_i,
    input  logic       br_jalr_i,
    input  logic       trap_i,
    input  addr_t      br_alu_res_i,
    input  addr_t      br_pc_i,
    input  addr_t      br_imm_i,
    input  addr_t      br_rs1_i,
    input  addr_t      mtvec_i,

    // decode side
    input  logic       stall_i,
    output logic       inst_valid_o,
    output inst_t      inst_o,
    output addr_t      pc_o
);

    addr_t pc;          // architectural fetch pc
    logic  pc_advance;
    logic  redirect;
    logic  accept;

    pc_next #(
        .RESET_PC(RESET_PC)
    ) pc_next_i (
        .clk(clk),
        .rst_i(rst_i),
        .br_jal_i(br_jal_i),
        .br_branch_i(br_branch_i),
        .br_jalr_i(br_jalr_i),
        .trap_i(trap_i),
        .pc_advance_i(pc_advance),
        .br_alu_res_i(br_alu_res_i),
        .br_pc_i(br_pc_i),
        .br_imm_i(br_imm_i),
        .br_rs1_i(br_rs1_i),
        .mtvec_i(mtvec_i),
        .pc_o(pc),
        .redirect_o(redirect)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk(clk),
        .rst_i(rst_i),
        .stall_i(stall_i),
        .redirect_i(redirect),
        .ar_ready_i(ar_ready_i),
        .r_valid_i(r_valid_i),
        .pc_i(pc),
        .ar_valid_o(ar_valid_o),
        .r_ready_o(r_ready_o),
        .pc_advance_o(pc_advance),
        .accept_o(accept),
        .ar_addr_o(ar_addr_o),
        .ar_size_o(ar_size_o)
    );

    // issued address doubles as the pc of the returned instruction
    inst_align inst_align_i (
        .clk(clk),
        .rst_i(rst_i),
        .accept_i(accept),
        .addr_i(ar_addr_o),
        .r_data_i(r_data_i),
        .inst_valid_o(inst_valid_o),
        .inst_o(inst_o),
        .pc_o(pc_o)
    );

endmodule

// File: logic/inst_align.sv
module inst_align import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      accept_i,  // beat matches the pc and may be issued
    input  addr_t     addr_i,    // address the beat was read from
    input  mem_word_u r_data_i,
    output logic      inst_valid_o,
    output inst_t     inst_o,
    output addr_t     pc_o
);

    inst_t inst_sel;

    // bit 2 picks the upper slot of the 8-byte word
    assign inst_sel = addr_i[2] ? r_data_i.half[1] : r_data_i.half[0];

    // one-cycle strobe to decode with zero data otherwise
    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_valid_o <= 1'b0;
            inst_o       <= '0;
            pc_o         <= '0;
        end else if (accept_i) begin
            inst_valid_o <= 1'b1;
            inst_o       <= inst_sel;
            pc_o         <= addr_i;
        end else begin
            inst_valid_o <= 1'b0;
            inst_o       <= '0;
            pc_o         <= '0;
        end
    end

endmodule

// File: logic/pc_next.sv
module pc_next import fetch_pkg::*; #(
    parameter addr_t RESET_PC = 64'h8000_0000
) (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  br_jal_i,
    input  logic  br_branch_i,
    input  logic  br_jalr_i,
    input  logic  trap_i,
    input  logic  pc_advance_i,  // current pc was fetched and issued
    input  addr_t br_alu_res_i,  // zero means branch taken
    input  addr_t br_pc_i,
    input  addr_t br_imm_i,
    input  addr_t br_rs1_i,
    input  addr_t mtvec_i,
    output addr_t pc_o,
    output logic  redirect_o
);

    logic  take_jal;     // jal or taken branch
    addr_t jal_target;   // pc relative target
    addr_t jalr_sum;
    addr_t jalr_target;  // register target with bit 0 cleared
    addr_t pc_plus4;

    assign take_jal = br_jal_i | (br_branch_i & (br_alu_res_i == '0));

    assign jal_target  = br_pc_i + br_imm_i;
    assign jalr_sum    = br_rs1_i + br_imm_i;
    assign jalr_target = {jalr_sum[63:1], 1'b0};
    assign pc_plus4    = pc_o + 64'd4;

    // a not-taken branch leaves the sequence alone
    assign redirect_o = take_jal | br_jalr_i | trap_i;

    // redirects first in the order jal or branch, then jalr, then trap
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o <= RESET_PC;
        end else if (take_jal) begin
            pc_o <= jal_target;
        end else if (br_jalr_i) begin
            pc_o <= jalr_target;
        end else if (trap_i) begin
            pc_o <= mtvec_i;  // trap vector from the csr file
        end else if (pc_advance_i) begin
            pc_o <= pc_plus4;
        end
    end

endmodule
